// File: Makefile
# Verilator build and run of the instruction fetch testbench.

SIM        = verilator
TOP        = tb_fetch_top
RTL_TOP    = fetch_top
FILELIST   = all.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_FLAGS  = --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing --top-module $(RTL_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+include
design/fetch_pkg.sv
design/pc_gen.sv
design/icache.sv
design/fetch_buf.sv
design/fetch_ctrl.sv
design/fetch_top.sv
test/tb_fetch_top.sv

// File: design/fetch_buf.sv
module fetch_buf
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        load_i,
  input  fetch_item_t item_i,
  input  logic        flush_i,
  input  logic        out_ready_i,
  output logic        can_load_o,
  output logic        out_valid_o,
  output fetch_item_t out_o
);

  logic        valid_q;
  fetch_item_t item_q;

  assign can_load_o = !valid_q || out_ready_i;         // Empty, or drains this edge.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (load_i)
    begin
      valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      valid_q <= 1'b0;                                 // Consumed, nothing behind it.
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
    begin
      item_q <= item_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = item_q;

endmodule

// File: design/fetch_ctrl.sv
module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] pc_i,
  input  logic              hit_i,
  input  logic [DATA_W-1:0] hit_data_i,
  input  logic              can_load_i,
  input  logic              redirect_valid_i,
  input  bus_rsp_t          bus_rsp_i,
  output bus_req_t          bus_req_o,
  output cache_fill_t       fill_o,
  output logic              advance_o,
  output logic              load_o,
  output fetch_item_t       item_o
);

  typedef enum logic [1:0] {
    LOOKUP,
    MISS,
    DROP
  } state_t;

  state_t            state_q;
  state_t            state_d;
  logic [ADDR_W-1:0] miss_addr_q;
  logic              in_lookup;
  logic              waiting;
  logic              rsp_now;
  logic              deliver;

  assign in_lookup = (state_q == LOOKUP);
  assign waiting   = (state_q == MISS) || (state_q == DROP);
  assign rsp_now   = waiting && bus_rsp_i.rvalid;

  // An item is ready from the cache in LOOKUP or from the bus in MISS.
  assign deliver = (in_lookup && hit_i) || ((state_q == MISS) && bus_rsp_i.rvalid);

  assign load_o    = deliver && can_load_i && !redirect_valid_i;
  assign advance_o = load_o;

  assign item_o.pc   = pc_i;
  assign item_o.inst = in_lookup ? hit_data_i : bus_rsp_i.rdata;

  assign bus_req_o.arvalid = waiting;                  // Held until the response.
  assign bus_req_o.araddr  = miss_addr_q;

  // Every response is written, even one dropped after a redirect.
  assign fill_o.we   = rsp_now;
  assign fill_o.addr = miss_addr_q;
  assign fill_o.data = bus_rsp_i.rdata;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LOOKUP:
      begin
        if (!hit_i && !redirect_valid_i)
        begin
          state_d = MISS;                              // pc is stable, go fetch it.
        end
      end
      MISS:
      begin
        if (bus_rsp_i.rvalid)
        begin
          state_d = LOOKUP;
        end
        else if (redirect_valid_i)
        begin
          state_d = DROP;                              // Stale read still in flight.
        end
      end
      DROP:
      begin
        if (bus_rsp_i.rvalid)
        begin
          state_d = LOOKUP;
        end
      end
      default:
      begin
        state_d = LOOKUP;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= LOOKUP;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_lookup && (state_d == MISS))
    begin
      miss_addr_q <= {pc_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    end
  end

endmodule

// File: design/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int IDX_W  = 8;                           // 256 lines.
  localparam int OFS_W  = 2;                           // One word per line.
  localparam int TAG_W  = ADDR_W - IDX_W - OFS_W;

  localparam logic [ADDR_W-1:0] RESET_PC_VAL = `RESET_PC;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
  } fetch_item_t;

  typedef struct packed {
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
  } bus_req_t;

  typedef struct packed {
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cache_fill_t;

endpackage

// File: design/fetch_top.sv
module fetch_top
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  output bus_req_t          bus_req_o,
  input  bus_rsp_t          bus_rsp_i,
  input  logic              out_ready_i,
  output logic              out_valid_o,
  output fetch_item_t       out_o
);

  logic [ADDR_W-1:0] pc;
  logic              advance;
  logic              hit;
  logic [DATA_W-1:0] hit_data;
  cache_fill_t       fill;
  logic              load;
  fetch_item_t       item;
  logic              can_load;

  pc_gen u_pc_gen (
    .clk              (clk),
    .rst              (rst),
    .advance_i        (advance),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .pc_o             (pc)
  );

  icache u_icache (
    .clk        (clk),
    .rst        (rst),
    .pc_i       (pc),
    .fill_i     (fill),
    .hit_o      (hit),
    .hit_data_o (hit_data)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk              (clk),
    .rst              (rst),
    .pc_i             (pc),
    .hit_i            (hit),
    .hit_data_i       (hit_data),
    .can_load_i       (can_load),
    .redirect_valid_i (redirect_valid_i),
    .bus_rsp_i        (bus_rsp_i),
    .bus_req_o        (bus_req_o),
    .fill_o           (fill),
    .advance_o        (advance),
    .load_o           (load),
    .item_o           (item)
  );

  // Redirect also empties the stage register.
  fetch_buf u_fetch_buf (
    .clk         (clk),
    .rst         (rst),
    .load_i      (load),
    .item_i      (item),
    .flush_i     (redirect_valid_i),
    .out_ready_i (out_ready_i),
    .can_load_o  (can_load),
    .out_valid_o (out_valid_o),
    .out_o       (out_o)
  );

endmodule

// File: design/icache.sv
module icache
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] pc_i,
  input  cache_fill_t       fill_i,
  output logic              hit_o,
  output logic [DATA_W-1:0] hit_data_o
);

  localparam int LINES = 1 << IDX_W;

  logic [DATA_W-1:0] data_mem [LINES];
  logic [TAG_W-1:0]  tag_mem  [LINES];
  logic [LINES-1:0]  valid_q;

  logic [TAG_W-1:0]  pc_tag;
  logic [IDX_W-1:0]  pc_idx;
  logic [TAG_W-1:0]  fill_tag;
  logic [IDX_W-1:0]  fill_idx;

  logic              line_valid;
  logic [TAG_W-1:0]  line_tag;

  // Address split: tag | index | byte offset.
  assign pc_tag   = pc_i[ADDR_W-1 -: TAG_W];
  assign pc_idx   = pc_i[OFS_W +: IDX_W];
  assign fill_tag = fill_i.addr[ADDR_W-1 -: TAG_W];
  assign fill_idx = fill_i.addr[OFS_W +: IDX_W];

  assign line_valid = valid_q[pc_idx];
  assign line_tag   = tag_mem[pc_idx];

  assign hit_o      = line_valid && (line_tag == pc_tag);
  assign hit_data_o = data_mem[pc_idx];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;                                   // Cold cache after reset.
    end
    else if (fill_i.we)
    begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i.we)
    begin
      data_mem[fill_idx] <= fill_i.data;
      tag_mem[fill_idx]  <= fill_tag;
    end
  end

endmodule

// File: design/pc_gen.sv
module pc_gen
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              advance_i,
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  output logic [ADDR_W-1:0] pc_o
);

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_seq;

  assign pc_seq = pc_q + ADDR_W'(4);                  // Next sequential word.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC_VAL;
    end
    else if (redirect_valid_i)
    begin
      pc_q <= redirect_pc_i;                           // Redirect wins over advance.
    end
    else if (advance_i)
    begin
      pc_q <= pc_seq;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Boot address of the fetch stage.
// The core's build may point this at a different boot ROM.
`define RESET_PC 32'h8000_0000

`endif

// File: test/tb_fetch_top.sv
module tb_fetch_top
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LIMIT = 2000;                         // Cycles allowed per wait.

  logic              clk;
  logic              rst;
  logic              redirect_valid_i;
  logic [ADDR_W-1:0] redirect_pc_i;
  bus_req_t          bus_req_o;
  bus_rsp_t          bus_rsp_i;
  logic              out_ready_i;
  logic              out_valid_o;
  fetch_item_t       out_o;

  logic [31:0]       lfsr_q = 32'd73488;
  logic              stall_en = 1'b0;
  int unsigned       req_count [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] exp_pc = RESET_PC_VAL;
  int                items = 0;                        // Items since the last redirect.
  logic              hold_pending = 1'b0;
  fetch_item_t       held_item;
  logic [ADDR_W-1:0] stale_addr;

  fetch_top UUT (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .bus_req_o        (bus_req_o),
    .bus_rsp_i        (bus_rsp_i),
    .out_ready_i      (out_ready_i),
    .out_valid_o      (out_valid_o),
    .out_o            (out_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Memory contents hashed from the whole address.
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] mixed;
    mixed = addr * 32'h9E37_79B1;
    return mixed ^ {addr[15:0], addr[31:16]} ^ 32'h0013_5A5A;
  endfunction

  function automatic fetch_item_t expected_item(input logic [ADDR_W-1:0] pc);
    fetch_item_t it;
    it.pc   = pc;
    it.inst = mem_word(pc);
    return it;
  endfunction

  // Program order with redirects taking priority.
  function automatic logic [ADDR_W-1:0] next_expected_pc(input logic [ADDR_W-1:0] pc,
                                                         input logic took, input logic redir,
                                                         input logic [ADDR_W-1:0] target);
    if (redir)
      return target;
    if (took)
      return pc + 32'd4;
    return pc;
  endfunction

  function automatic int unsigned requests_for(input logic [ADDR_W-1:0] addr);
    return req_count.exists(addr) ? req_count[addr] : 0;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("FAILED at %0t: %s, got %h, expected %h",
                                  $time, what, got, exp));
  endtask

  // Memory model and decode ready driven on the falling edge.
  initial
  begin
    logic              busy;
    int                wait_left;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       bits;
    busy        = 1'b0;
    wait_left   = 0;
    addr        = '0;
    bus_rsp_i   = '0;
    out_ready_i = 1'b0;
    forever
    begin
      @(negedge clk);
      bus_rsp_i.rvalid = 1'b0;
      if (rst)
      begin
        busy = 1'b0;
      end
      else if (busy)
      begin
        check_equal(64'(bus_req_o.arvalid), 64'(1), "arvalid dropped before rvalid");
        check_equal(64'(bus_req_o.araddr), 64'(addr), "araddr changed while held");
        wait_left = wait_left - 1;
        if (wait_left == 0)
        begin
          bus_rsp_i.rvalid = 1'b1;
          bus_rsp_i.rdata  = mem_word(addr);
          busy             = 1'b0;
        end
      end
      else if (bus_req_o.arvalid)
      begin
        addr            = bus_req_o.araddr;
        req_count[addr] = requests_for(addr) + 1;
        bits            = take_bits(2);
        wait_left       = 1 + int'(bits[1:0]);         // 1 to 4 cycles.
        busy            = 1'b1;
      end
      if (stall_en)
      begin
        bits        = take_bits(1);
        out_ready_i = bits[0];
      end
      else
      begin
        out_ready_i = 1'b1;
      end
    end
  end

  // Compare process sampled at the rising edge.
  initial
  begin
    logic took;
    forever
    begin
      @(posedge clk);
      if (rst)
      begin
        hold_pending = 1'b0;
        items        = 0;
        exp_pc       = RESET_PC_VAL;
      end
      else
      begin
        if (hold_pending)
        begin
          check_equal(64'(out_valid_o), 64'(1), "item lost while decode stalled");
          check_equal(64'(out_o), 64'(held_item), "out_o changed while decode stalled");
        end
        took = out_valid_o && out_ready_i;
        if (took)
          check_equal(64'(out_o), 64'(expected_item(exp_pc)), "item at decode");
        hold_pending = out_valid_o && !out_ready_i && !redirect_valid_i;
        held_item    = out_o;
        exp_pc       = next_expected_pc(exp_pc, took, redirect_valid_i, redirect_pc_i);
        if (redirect_valid_i)
          items = 0;
        else if (took)
          items = items + 1;
      end
    end
  end

  // Called and returns at a falling edge.
  task automatic redirect_to(input logic [ADDR_W-1:0] target);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    @(negedge clk);
    redirect_valid_i = 1'b0;
  endtask

  task automatic wait_items(input int n);
    int cycles;
    cycles = 0;
    while (items < n)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > LIMIT)
        stop_with_failure($sformatf("Timeout: only %0d of %0d items reached decode", items, n));
    end
  endtask

  task automatic wait_miss_start();
    int   cycles;
    logic prev;
    cycles = 0;
    prev   = bus_req_o.arvalid;
    @(negedge clk);
    while (!(bus_req_o.arvalid && !prev))
    begin
      prev = bus_req_o.arvalid;
      @(negedge clk);
      cycles++;
      if (cycles > LIMIT)
        stop_with_failure("Timeout: the fetch stage never started a bus read");
    end
  endtask

  task automatic check_requests(input logic [ADDR_W-1:0] base, input int n, input int exp);
    for (int i = 0; i < n; i++)
      check_equal(64'(requests_for(base + 32'(4 * i))), 64'(exp), "bus reads per address");
  endtask

  initial
  begin
    rst              = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_equal(64'(out_valid_o), 64'(0), "out_valid_o after reset");
    check_equal(64'(bus_req_o.arvalid), 64'(0), "arvalid after reset");

    wait_items(40);                                    // Sequential run from the boot address.
    check_requests(RESET_PC_VAL, 40, 1);

    repeat (3)
    begin
      redirect_to(RESET_PC_VAL + 32'h20);              // Loop body already in the cache.
      wait_items(8);
    end
    check_requests(RESET_PC_VAL, 40, 1);

    redirect_to(RESET_PC_VAL + 32'h410);               // Same index as +0x10 with another tag.
    wait_items(1);
    check_equal(64'(requests_for(RESET_PC_VAL + 32'h410)), 64'(1), "reads of aliased line");
    redirect_to(RESET_PC_VAL + 32'h10);
    wait_items(1);
    check_equal(64'(requests_for(RESET_PC_VAL + 32'h10)), 64'(2), "reads after eviction");

    stale_addr = RESET_PC_VAL + 32'h1000;
    redirect_to(stale_addr);
    wait_miss_start();
    check_equal(64'(bus_req_o.araddr), 64'(stale_addr), "miss address of redirect target");
    redirect_to(RESET_PC_VAL + 32'h2000);
    check_equal(64'(bus_req_o.arvalid), 64'(1), "stale read held after redirect");
    check_equal(64'(bus_req_o.araddr), 64'(stale_addr), "stale read address");
    wait_items(3);

    @(posedge clk);
    stall_en = 1'b1;
    @(negedge clk);
    redirect_to(RESET_PC_VAL);
    wait_items(60);
    @(posedge clk);
    stall_en = 1'b0;
    @(negedge clk);

    $display(">>> PASS");
    $finish;
  end

endmodule
